/* files.f */
+incdir+rtl
rtl/wisc_pkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/decode.sv
rtl/wiscCore.sv
testbench/wiscCore_asserts.sv
testbench/wiscCore_tb.sv

/* Makefile */
# Verilator build and run of the wiscCore testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module wiscCore_tb -f files.f -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/wiscCore_tb.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module wiscCore_tb;

   import wisc_pkg::*;

   logic                clk;
   logic                rstN;
   logic [`DATA_W-1:0]  instr;
   logic                instrValid;
   logic                instrReady;
   logic [`DATA_W-1:0]  pc;
   logic                wbValid;
   logic [2:0]          wbReg;
   logic [`DATA_W-1:0]  wbData;
   logic                halted;
   logic                err;

   // Reference model of the architectural state
   logic [`DATA_W-1:0]  mReg [`REG_CNT];
   logic [`DATA_W-1:0]  mMem [`DMEM_DEPTH];
   logic [`DATA_W-1:0]  mPc;

   // Writeback captured in the accepting cycle
   logic                sawWb;
   logic [2:0]          sawReg;
   logic [`DATA_W-1:0]  sawData;

   logic [31:0]         lfsr;
   int                  errors;
   int                  checks;

   wiscCore dut_i (
      .clk        (clk),
      .rstN       (rstN),
      .instr      (instr),
      .instrValid (instrValid),
      .instrReady (instrReady),
      .pc         (pc),
      .wbValid    (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .halted     (halted),
      .err        (err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////
   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsrBit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [`DATA_W-1:0] randomBits(input int n);
      logic [`DATA_W-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[`DATA_W-2:0], lfsrBit()};
      end
      return v;
   endfunction

   // Any register but the link register
   function automatic logic [2:0] lowReg();
      logic [2:0] r;
      r = 3'(randomBits(3));
      return (r == 3'd7) ? 3'd0 : r;
   endfunction

   // Instruction formats
   function automatic logic [15:0] immForm(opcodeT op, logic [2:0] rs, logic [2:0] rt,
                                           logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] regForm(logic [2:0] rs, logic [2:0] rt, logic [2:0] rd,
                                           logic [1:0] fn);
      return {opAluRr, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] byteForm(opcodeT op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] jumpForm(opcodeT op, logic [10:0] imm);
      return {op, imm};
   endfunction

   task automatic checkVal(input string name, input string what,
                           input logic [`DATA_W-1:0] exp, input logic [`DATA_W-1:0] act);
      checks++;
      assert (exp === act) else begin
         errors++;
         $display("ERR %s %s expected %h actual %h", name, what, exp, act);
      end
   endtask

   task automatic applyReset();
      rstN = 1'b0;
      instrValid = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      rstN = 1'b1;
      mPc = '0;
      for (int r = 0; r < `REG_CNT; r++) begin
         mReg[r] = '0;
      end
   endtask

   // Offer a word from just after an edge until accepted or out of cycles
   task automatic issue(input logic [`DATA_W-1:0] word, input int limit,
                        output logic accepted);
      int cycles;
      accepted = 1'b0;
      cycles = 0;
      sawWb = 1'b0;
      instr = word;
      instrValid = 1'b1;
      while (!accepted && cycles < limit) begin
         // Inputs and combinational outputs are settled by mid cycle
         @(negedge clk);
         if (instrReady) begin
            accepted = 1'b1;
            sawWb = wbValid;
            sawReg = wbReg;
            sawData = wbData;
         end
         @(posedge clk);
         #2;
         cycles++;
      end
      instrValid = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Reference execution of one instruction
   ////////////////////////////////////////////////////////////
   task automatic step(input logic [`DATA_W-1:0] w, input string name);
      opcodeT             op;
      logic [2:0]         s;
      logic [2:0]         d;
      logic [`DATA_W-1:0] a;
      logic [`DATA_W-1:0] b;
      logic [`DATA_W-1:0] i5;
      logic [`DATA_W-1:0] z5;
      logic [`DATA_W-1:0] i8;
      logic [`DATA_W-1:0] i11;
      logic [`DATA_W-1:0] addr;
      logic [`DATA_W-1:0] ret;
      logic [`DATA_W-1:0] res;
      logic [`DATA_W-1:0] npc;
      logic               we;
      logic               ok;
      op = opcodeT'(w[15:11]);
      s = w[10:8];
      d = w[7:5];
      a = mReg[s];
      b = mReg[w[7:5]];
      i5 = {{11{w[4]}}, w[4:0]};
      z5 = {11'd0, w[4:0]};
      i8 = {{8{w[7]}}, w[7:0]};
      i11 = {{5{w[10]}}, w[10:0]};
      addr = a + i5;
      ret = mPc + 16'd2;
      npc = ret;
      res = '0;
      we = 1'b1;
      // Register results
      case (op)
         opAddi:  res = a + i5;
         opSubi:  res = i5 - a;
         opXori:  res = a ^ z5;
         opAndni: res = a & ~z5;
         opLd:    res = mMem[addr[8:1]];
         opLbi: begin
            d = s;
            res = i8;
         end
         opSlbi: begin
            d = s;
            res = {a[7:0], w[7:0]};
         end
         opAluRr: begin
            d = w[4:2];
            case (w[1:0])
               2'b00:   res = a + b;
               2'b01:   res = b - a;
               2'b10:   res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         // Links go to R7
         opJal, opJalr: begin
            d = 3'd7;
            res = ret;
         end
         default: we = 1'b0;
      endcase
      // Next pc
      case (op)
         opBeqz:       npc = (a == 16'd0) ? ret + i8 : ret;
         opBnez:       npc = (a != 16'd0) ? ret + i8 : ret;
         opBltz:       npc = a[15] ? ret + i8 : ret;
         opBgez:       npc = a[15] ? ret : ret + i8;
         opJ, opJal:   npc = ret + i11;
         opJr, opJalr: npc = a + i8;
         default: ;
      endcase
      issue(w, 8, ok);
      checks++;
      assert (ok) else begin
         errors++;
         $display("Instruction %s was never accepted, instrReady stayed low", name);
      end
      checkVal(name, "wbValid", 16'(we), 16'(sawWb));
      if (we) begin
         checkVal(name, "wbReg", 16'(d), 16'(sawReg));
         checkVal(name, "wbData", res, sawData);
         mReg[d] = res;
      end
      if (op == opSt) begin
         mMem[addr[8:1]] = b;
      end
      checkVal(name, "pc", npc, pc);
      mPc = npc;
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////
   task automatic resetTest();
      checkVal("reset", "pc", 16'h0000, pc);
      checkVal("reset", "instrReady", 16'd1, 16'(instrReady));
      checkVal("reset", "halted", 16'd0, 16'(halted));
      checkVal("reset", "err", 16'd0, 16'(err));
      // A word on the bus without valid must do nothing
      instr = immForm(opAddi, 3'd0, 3'd1, 5'd5);
      repeat (5) begin
         @(negedge clk);
         checkVal("idle", "wbValid", 16'd0, 16'(wbValid));
         @(posedge clk);
         #2;
         checkVal("idle", "pc", 16'h0000, pc);
      end
   endtask

   task automatic arithTest();
      logic [2:0] s;
      logic [2:0] t;
      logic [2:0] d;
      logic [4:0] imm;
      opcodeT     op;
      // Seed R0..R6
      for (int r = 0; r < 7; r++) begin
         step(byteForm(opLbi, 3'(r), 8'(randomBits(8))), "lbi");
         step(byteForm(opSlbi, 3'(r), 8'(randomBits(8))), "slbi");
      end
      for (int n = 0; n < 24; n++) begin
         s = 3'(randomBits(3));
         t = lowReg();
         d = lowReg();
         imm = 5'(randomBits(5));
         case (n % 4)
            0:       op = opAddi;
            1:       op = opSubi;
            2:       op = opXori;
            default: op = opAndni;
         endcase
         step(immForm(op, s, t, imm), "arith imm");
         step(regForm(s, t, d, 2'(n % 4)), "arith reg");
      end
      // A set top immediate bit separates zero from sign extension
      step(byteForm(opLbi, 3'd1, 8'h80), "ext setup");
      step(immForm(opXori, 3'd1, 3'd2, 5'h1f), "xori ext");
      step(immForm(opAndni, 3'd1, 3'd3, 5'h10), "andni ext");
      step(jumpForm(opNop, 11'd0), "nop");
      // R7 still reads zero
      step(immForm(opAddi, 3'd7, 3'd0, 5'd0), "r7 check");
   endtask

   task automatic memTest();
      logic [`DATA_W-1:0] rnd;
      logic [4:0]         off;
      for (int n = 0; n < 4; n++) begin
         rnd = randomBits(7);
         step(byteForm(opLbi, 3'd1, {rnd[6:0], 1'b0}), "mem base");
         step(byteForm(opLbi, 3'd2, 8'(randomBits(8))), "mem data");
         step(byteForm(opSlbi, 3'd2, 8'(randomBits(8))), "mem data");
         rnd = randomBits(4);
         off = {rnd[3:0], 1'b0};
         step(immForm(opSt, 3'd1, 3'd2, off), "st");
         // Clear R2 so the value must come back from memory
         step(byteForm(opLbi, 3'd2, 8'h00), "mem clear");
         step(immForm(opLd, 3'd1, 3'(n + 3), off), "ld");
      end
   endtask

   task automatic branchTest();
      logic [`DATA_W-1:0] rnd;
      logic [7:0]         ofs;
      // Zero, positive and negative test values
      step(byteForm(opLbi, 3'd1, 8'h00), "br setup");
      step(byteForm(opLbi, 3'd2, 8'h05), "br setup");
      step(byteForm(opLbi, 3'd3, 8'hfa), "br setup");
      for (int r = 1; r < 4; r++) begin
         rnd = randomBits(6);
         // Even and never zero so taken and untaken land apart
         ofs = {rnd[5:0], 2'b10};
         step(byteForm(opBeqz, 3'(r), ofs), "beqz");
         step(byteForm(opBnez, 3'(r), ofs), "bnez");
         step(byteForm(opBltz, 3'(r), ofs), "bltz");
         step(byteForm(opBgez, 3'(r), ofs), "bgez");
      end
      step(jumpForm(opJ, 11'h7f0), "j");
      step(jumpForm(opJal, 11'h024), "jal");
      step(byteForm(opJr, 3'd2, 8'h10), "jr");
      step(byteForm(opJalr, 3'd3, 8'hf8), "jalr");
      // Return through the link register
      step(byteForm(opJalr, 3'd7, 8'h00), "jalr r7");
      step(byteForm(opJr, 3'd7, 8'h02), "jr r7");
   endtask

   task automatic haltTest();
      logic ok;
      step(jumpForm(opHalt, 11'd0), "halt");
      checkVal("halt", "halted", 16'd1, 16'(halted));
      checkVal("halt", "instrReady", 16'd0, 16'(instrReady));
      // Further offers are refused
      issue(immForm(opAddi, 3'd1, 3'd2, 5'd1), 4, ok);
      checkVal("halt", "accepted", 16'd0, 16'(ok));
      checkVal("halt", "pc", mPc, pc);
   endtask

   task automatic illegalTest();
      logic ok;
      applyReset();
      // Compare opcode group is not implemented
      issue({5'b11100, 3'd1, 3'd2, 5'd0}, 8, ok);
      checkVal("illegal", "accepted", 16'd1, 16'(ok));
      checkVal("illegal", "wbValid", 16'd0, 16'(sawWb));
      checkVal("illegal", "err", 16'd1, 16'(err));
      checkVal("illegal", "halted", 16'd1, 16'(halted));
      checkVal("illegal", "instrReady", 16'd0, 16'(instrReady));
   endtask

   initial begin
      lfsr = 32'h951e5f24;
      errors = 0;
      checks = 0;
      instr = '0;
      instrValid = 1'b0;
      rstN = 1'b0;
      applyReset();
      resetTest();
      arithTest();
      memTest();
      branchTest();
      haltTest();
      illegalTest();
      // Bound assertion failures count against the run
      errors += dut_i.asserts_i.failCount;
      $display("Checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* testbench/wiscCore_asserts.sv */
`timescale 1ns/1ps

module wiscCore_asserts (
   input logic clk,
   input logic rstN,
   input logic instrValid,
   input logic instrReady,
   input logic wbValid,
   input logic halted,
   input logic err
);

   // Assertion failures seen so far
   int failCount = 0;

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////
   // Writeback only in an accepting cycle
   wbNeedsXfer: assert property (@(posedge clk) disable iff (!rstN)
      wbValid |-> (instrValid && instrReady))
      else begin
         $error("wbValid high without an instruction transfer");
         failCount++;
      end

   // A halted core takes nothing
   readyWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
      halted |-> !instrReady)
      else begin
         $error("instrReady high while halted");
         failCount++;
      end

   ////////////////////////////////////////////////////////////
   // Reset
   ////////////////////////////////////////////////////////////
   cleanAfterReset: assert property (@(posedge clk)
      !rstN |=> (!wbValid && !halted && !err))
      else begin
         $error("wbValid, halted or err high in the cycle after reset");
         failCount++;
      end

endmodule

bind wiscCore wiscCore_asserts asserts_i (
   .clk        (clk),
   .rstN       (rstN),
   .instrValid (instrValid),
   .instrReady (instrReady),
   .wbValid    (wbValid),
   .halted     (halted),
   .err        (err)
);

/* rtl/wiscCore.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module wiscCore (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [`DATA_W-1:0]           instr,
   input  logic                         instrValid,
   output logic                         instrReady,
   output logic [`DATA_W-1:0]           pc,
   output logic                         wbValid,
   output logic [$clog2(`REG_CNT)-1:0] wbReg,
   output logic [`DATA_W-1:0]           wbData,
   output logic                         halted,
   output logic                         err
);

   import wisc_pkg::*;

   logic [`DATA_W-1:0]           rsData;
   logic [`DATA_W-1:0]           rtData;
   logic [`DATA_W-1:0]           imm5;
   logic [`DATA_W-1:0]           imm8;
   logic [`DATA_W-1:0]           imm11;
   aluOpT                        aluOp;
   logic                         invA;
   logic                         invB;
   bSrcT                         bSrc;
   brTypeT                       brType;
   logic                         memWrt;
   logic                         memRead;
   wbSrcT                        wbSrc;
   logic [$clog2(`REG_CNT)-1:0] dstReg;
   logic                         regWrt;
   logic                         halt;
   logic                         illegal;
   logic [`DATA_W-1:0]           bOperand;
   logic [`DATA_W-1:0]           aluResult;
   logic                         aluZero;
   logic                         aluNeg;
   logic [`DATA_W-1:0]           memRdData;
   logic [`DATA_W-1:0]           loadData;
   logic [`DATA_W-1:0]           pcInc;
   logic [`DATA_W-1:0]           nextPc;
   logic                         brTaken;
   logic                         xfer;
   logic                         wbEn;

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////
   // Ready until HALT or an illegal opcode is accepted
   assign instrReady = ~halted;
   assign xfer       = instrValid & instrReady;

   decode iDecode (
      .clk     (clk),
      .rstN    (rstN),
      .instr   (instr),
      .wbEn    (wbEn),
      .wbReg   (dstReg),
      .wbData  (wbData),
      .rs      (rsData),
      .rt      (rtData),
      .imm5    (imm5),
      .imm8    (imm8),
      .imm11   (imm11),
      .aluOp   (aluOp),
      .invA    (invA),
      .invB    (invB),
      .bSrc    (bSrc),
      .brType  (brType),
      .memWrt  (memWrt),
      .memRead (memRead),
      .wbSrc   (wbSrc),
      .dstReg  (dstReg),
      .regWrt  (regWrt),
      .halt    (halt),
      .illegal (illegal)
   );

   // SLBI shifts the low byte of Rs up into operand B
   always_comb begin
      case (bSrc)
         bImm5:   bOperand = imm5;
         bImm8:   bOperand = imm8;
         bSlbi:   bOperand = {rsData[7:0], imm8[7:0]};
         default: bOperand = rtData;
      endcase
   end

   alu iAlu (
      .a      (rsData),
      .b      (bOperand),
      .op     (aluOp),
      .invA   (invA),
      .invB   (invB),
      .result (aluResult),
      .zero   (aluZero),
      .neg    (aluNeg)
   );

   dataMem iDataMem (
      .clk    (clk),
      .addr   (aluResult),
      .wrData (rtData),
      .wrEn   (xfer & memWrt),
      .rdData (memRdData)
   );

   assign loadData = memRead ? memRdData : '0;

   ////////////////////////////////////////////////////////////
   // Next pc
   ////////////////////////////////////////////////////////////
   assign pcInc = pc + `DATA_W'(2);

   always_comb begin
      case (brType)
         brBeqz:  brTaken = aluZero;
         brBnez:  brTaken = ~aluZero;
         brBltz:  brTaken = aluNeg;
         brBgez:  brTaken = ~aluNeg;
         default: brTaken = 1'b0;
      endcase
   end

   always_comb begin
      case (brType)
         brJump:    nextPc = pcInc + imm11;
         // Rs plus imm8 from the ALU
         brJumpReg: nextPc = aluResult;
         default:   nextPc = brTaken ? pcInc + imm8 : pcInc;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Writeback
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (wbSrc)
         wbMem:   wbData = loadData;
         wbRet:   wbData = pcInc;
         wbB:     wbData = bOperand;
         default: wbData = aluResult;
      endcase
   end

   // Register write only on an accepted instruction
   assign wbEn    = xfer & regWrt;
   assign wbValid = wbEn;
   assign wbReg   = dstReg;

   // State moves only on a transfer
   // HALT still advances pc by the default rule
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (xfer) begin
         pc <= nextPc;
         if (halt | illegal) begin
            halted <= 1'b1;
         end
         if (illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

/* rtl/decode.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module decode (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [`DATA_W-1:0]           instr,
   input  logic                         wbEn,
   input  logic [$clog2(`REG_CNT)-1:0] wbReg,
   input  logic [`DATA_W-1:0]           wbData,
   output logic [`DATA_W-1:0]           rs,
   output logic [`DATA_W-1:0]           rt,
   output logic [`DATA_W-1:0]           imm5,
   output logic [`DATA_W-1:0]           imm8,
   output logic [`DATA_W-1:0]           imm11,
   output wisc_pkg::aluOpT              aluOp,
   output logic                         invA,
   output logic                         invB,
   output wisc_pkg::bSrcT               bSrc,
   output wisc_pkg::brTypeT             brType,
   output logic                         memWrt,
   output logic                         memRead,
   output wisc_pkg::wbSrcT              wbSrc,
   output logic [$clog2(`REG_CNT)-1:0] dstReg,
   output logic                         regWrt,
   output logic                         halt,
   output logic                         illegal
);

   import wisc_pkg::*;

   opcodeT     opcode;
   logic [1:0] func;
   logic       zeroExt;

   assign opcode = opcodeT'(instr[15:11]);
   // Function field of the register arithmetic format
   assign func   = instr[1:0];

   ////////////////////////////////////////////////////////////
   // Control from opcode
   ////////////////////////////////////////////////////////////
   always_comb begin
      aluOp   = aluAdd;
      invA    = 1'b0;
      invB    = 1'b0;
      bSrc    = bRt;
      brType  = brNone;
      memWrt  = 1'b0;
      memRead = 1'b0;
      wbSrc   = wbAlu;
      dstReg  = instr[7:5];
      regWrt  = 1'b0;
      halt    = 1'b0;
      illegal = 1'b0;
      zeroExt = 1'b0;
      case (opcode)
         opHalt: halt = 1'b1;
         opNop: ;
         // Immediate arithmetic writes the Rt field
         opAddi: begin
            bSrc   = bImm5;
            regWrt = 1'b1;
         end
         // Imm minus Rs
         opSubi: begin
            bSrc   = bImm5;
            invA   = 1'b1;
            regWrt = 1'b1;
         end
         opXori: begin
            aluOp   = aluXor;
            bSrc    = bImm5;
            zeroExt = 1'b1;
            regWrt  = 1'b1;
         end
         opAndni: begin
            aluOp   = aluAnd;
            bSrc    = bImm5;
            invB    = 1'b1;
            zeroExt = 1'b1;
            regWrt  = 1'b1;
         end
         opBeqz: brType = brBeqz;
         opBnez: brType = brBnez;
         opBltz: brType = brBltz;
         opBgez: brType = brBgez;
         // Address is Rs plus imm5 for both memory ops
         opSt: begin
            bSrc   = bImm5;
            memWrt = 1'b1;
         end
         opLd: begin
            bSrc    = bImm5;
            memRead = 1'b1;
            wbSrc   = wbMem;
            regWrt  = 1'b1;
         end
         // Immediate loads write back into Rs
         opLbi: begin
            bSrc   = bImm8;
            wbSrc  = wbB;
            dstReg = instr[10:8];
            regWrt = 1'b1;
         end
         opSlbi: begin
            bSrc    = bSlbi;
            wbSrc   = wbB;
            zeroExt = 1'b1;
            dstReg  = instr[10:8];
            regWrt  = 1'b1;
         end
         opAluRr: begin
            dstReg = instr[4:2];
            regWrt = 1'b1;
            case (func)
               2'b01: invA = 1'b1;
               2'b10: aluOp = aluXor;
               2'b11: begin
                  aluOp = aluAnd;
                  invB  = 1'b1;
               end
               default: ;
            endcase
         end
         opJ: brType = brJump;
         opJal: begin
            brType = brJump;
            wbSrc  = wbRet;
            dstReg = 3'd7;
            regWrt = 1'b1;
         end
         // Jump target Rs plus imm8 comes out of the ALU
         opJr: begin
            brType = brJumpReg;
            bSrc   = bImm8;
         end
         opJalr: begin
            brType = brJumpReg;
            bSrc   = bImm8;
            wbSrc  = wbRet;
            dstReg = 3'd7;
            regWrt = 1'b1;
         end
         // Anything else stops the core with no side effects
         default: illegal = 1'b1;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Immediate extension
   ////////////////////////////////////////////////////////////
   assign imm5  = zeroExt ? {{(`DATA_W-5){1'b0}}, instr[4:0]}
                          : {{(`DATA_W-5){instr[4]}}, instr[4:0]};
   assign imm8  = zeroExt ? {{(`DATA_W-8){1'b0}}, instr[7:0]}
                          : {{(`DATA_W-8){instr[7]}}, instr[7:0]};
   // Jump displacement is always signed
   assign imm11 = {{(`DATA_W-11){instr[10]}}, instr[10:0]};

   regFile iRegFile (
      .clk     (clk),
      .rstN    (rstN),
      .rd1Sel  (instr[10:8]),
      .rd2Sel  (instr[7:5]),
      .wrSel   (wbReg),
      .wrData  (wbData),
      .wrEn    (wbEn),
      .rd1Data (rs),
      .rd2Data (rt)
   );

endmodule

/* rtl/dataMem.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module dataMem (
   input  logic               clk,
   input  logic [`DATA_W-1:0] addr,
   input  logic [`DATA_W-1:0] wrData,
   input  logic               wrEn,
   output logic [`DATA_W-1:0] rdData
);

   localparam int unsigned AddrW = $clog2(`DMEM_DEPTH);

   logic [`DATA_W-1:0] mem [`DMEM_DEPTH];
   logic [AddrW-1:0]   wordIdx;

   // Byte address to word index, bit 0 dropped
   assign wordIdx = addr[AddrW:1];

   // Contents survive reset
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wordIdx] <= wrData;
      end
   end

   // Asynchronous read for single cycle loads
   assign rdData = mem[wordIdx];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module alu (
   input  logic [`DATA_W-1:0] a,
   input  logic [`DATA_W-1:0] b,
   input  wisc_pkg::aluOpT    op,
   input  logic               invA,
   input  logic               invB,
   output logic [`DATA_W-1:0] result,
   output logic               zero,
   output logic               neg
);

   import wisc_pkg::*;

   logic [`DATA_W-1:0] aOp;
   logic [`DATA_W-1:0] bOp;
   logic               cin;
   logic [`DATA_W-1:0] sum;

   ////////////////////////////////////////////////////////////
   // Operand conditioning
   ////////////////////////////////////////////////////////////
   assign aOp = invA ? ~a : a;
   assign bOp = invB ? ~b : b;

   // Carry in completes the two's complement negate
   // (harmless for ANDN since the logic path ignores it)
   assign cin = invA | invB;

   assign sum = aOp + bOp + `DATA_W'(cin);

   ////////////////////////////////////////////////////////////
   // Result select
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (op)
         aluXor:  result = aOp ^ bOp;
         aluAnd:  result = aOp & bOp;
         default: result = sum;
      endcase
   end

   // Branch flags look at raw Rs
   assign zero = (a == '0);
   assign neg  = a[`DATA_W-1];

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps
`include "wisc_params.svh"

module regFile (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic [$clog2(`REG_CNT)-1:0] rd1Sel,
   input  logic [$clog2(`REG_CNT)-1:0] rd2Sel,
   input  logic [$clog2(`REG_CNT)-1:0] wrSel,
   input  logic [`DATA_W-1:0]           wrData,
   input  logic                         wrEn,
   output logic [`DATA_W-1:0]           rd1Data,
   output logic [`DATA_W-1:0]           rd2Data
);

   // Register storage
   logic [`DATA_W-1:0] regs [`REG_CNT];

   ////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////
   // All registers clear on reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////////////////////////
   // Combinational reads with no write bypass
   assign rd1Data = regs[rd1Sel];
   assign rd2Data = regs[rd2Sel];

endmodule

/* rtl/wisc_pkg.sv */
package wisc_pkg;

   ////////////////////////////////////////////////////////////
   // Major opcodes in instr[15:11]
   ////////////////////////////////////////////////////////////
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opLbi   = 5'b11000,
      // Register arithmetic with the function in instr[1:0]
      opAluRr = 5'b11011,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111
   } opcodeT;

   // SUB and ANDN come from add and and with operand inversion
   typedef enum logic [1:0] {
      aluAdd,
      aluXor,
      aluAnd
   } aluOpT;

   // ALU operand B source
   typedef enum logic [1:0] {
      bRt,
      bImm5,
      bImm8,
      bSlbi
   } bSrcT;

   // Register writeback source
   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbRet,
      wbB
   } wbSrcT;

   typedef enum logic [2:0] {
      brNone,
      brBeqz,
      brBnez,
      brBltz,
      brBgez,
      brJump,
      brJumpReg
   } brTypeT;

endpackage

/* rtl/wisc_params.svh */
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// Datapath and instruction word width
`define DATA_W 16

// Architectural registers R0..R7
`define REG_CNT 8

// Internal data memory size in words
`define DMEM_DEPTH 256

`endif
